//--- common/rpPkg.sv
////////////////////////////////////////////////////////////
// Register map and word layouts of one RP drive as seen
// from the massbus side. Registers are 16 bits wide
////////////////////////////////////////////////////////////

package rpPkg;

   // Width of the sector counter and of RPDA
   localparam int SectorBits = 6;

   // RPDS bit positions
   localparam int DsDry = 7;
   localparam int DsDmd = 0;

   // Register index, from bus address bits 4:2
   // Indexes 5 to 7 are unmapped
   typedef enum logic [2:0] {
      AddrCs1 = 3'd0,
      AddrDa  = 3'd1,
      AddrMr  = 3'd2,
      AddrLa  = 3'd3,
      AddrDs  = 3'd4
   } rpAddr_e;

   // Function field of RPCS1 (bits 5:1)
   // Codes match the octal command words 01, 11 and 31 with GO
   typedef enum logic [4:0] {
      FuncNop    = 5'd0,
      FuncDrvClr = 5'd4,
      FuncSearch = 5'd12
   } rpFunc_e;

   // RPCS1 layout
   typedef struct packed {
      logic       attn;
      logic [8:0] rsvd;
      rpFunc_e    func;
      logic       go;
   } rpCs1_s;

   // RPMR layout, bits 15:5 unused
   typedef struct packed {
      logic [10:0] rsvd;
      logic        ddat;
      logic        dsck;
      logic        dind;
      logic        dclk;
      logic        dmd;
   } rpMr_s;

   // One written data word, decoded by address
   typedef union packed {
      rpCs1_s      cs1;
      rpMr_s       mr;
      logic [15:0] raw;
   } rpWord_u;

endpackage

//--- common/rpBusIfs.sv
////////////////////////////////////////////////////////////
// Register write strobe is one clock wide per write
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

// Register write bus from the bus slave to the register blocks
interface rpRegBus
   import rpPkg::*;
();
   logic    wrEn;
   rpAddr_e wrAddr;
   rpWord_u wrData;

   modport master (output wrEn, output wrAddr, output wrData);
   modport target (input wrEn, input wrAddr, input wrData);
endinterface

// Diagnostic mode and pulses between maintenance and control
interface rpMaintIf;
   logic dmd;
   logic sectorPulse;
   logic indexPulse;
   logic busy;

   // Maintenance side owns the diagnostic signals
   modport maint (output dmd, output sectorPulse, output indexPulse, input busy);
   // Control side owns busy
   modport ctrl (input dmd, input sectorPulse, input indexPulse, output busy);
endinterface

//--- hdl/rpAxiSlave.sv
////////////////////////////////////////////////////////////
// AXI4-Lite slave, one outstanding write and one read
// Write strobes are ignored, responses are always OKAY
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rpAxiSlave
   import rpPkg::*;
(
   input  logic        clk,
   input  logic        rst,
   // Write address and data
   input  logic [4:0]  awAddr,
   input  logic        awValid,
   output logic        awReady,
   input  logic [31:0] wData,
   input  logic        wValid,
   output logic        wReady,
   // Write response
   output logic        bValid,
   input  logic        bReady,
   output logic [1:0]  bResp,
   // Read address
   input  logic [4:0]  arAddr,
   input  logic        arValid,
   output logic        arReady,
   // Read data
   output logic [31:0] rData,
   output logic        rValid,
   input  logic        rReady,
   output logic [1:0]  rResp,
   // Register side
   rpRegBus.master     regBus,
   input  logic [15:0] csWord,
   input  logic [15:0] daWord,
   input  logic [15:0] mrWord,
   input  logic [15:0] laWord,
   input  logic [15:0] dsWord
);

   localparam logic [1:0] RespOkay = 2'b00;

   logic        wrAccept;
   rpAddr_e     rdAddr;
   logic [15:0] rdWord;

   ////////////////////////////////////////////////////////////
   // Write channel

   // Address and data taken together, blocked while response waits
   assign wrAccept = awValid && wValid && !bValid;
   assign awReady  = wrAccept;
   assign wReady   = wrAccept;

   // Register write in the handshake cycle
   assign regBus.wrEn   = wrAccept;
   assign regBus.wrAddr = rpAddr_e'(awAddr[4:2]);
   assign regBus.wrData = rpWord_u'(wData[15:0]);

   // Response follows one clock later, held until taken
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         bValid <= 1'b0;
      else if (wrAccept)
         bValid <= 1'b1;
      else if (bReady)
         bValid <= 1'b0;
   end

   assign bResp = RespOkay;

   ////////////////////////////////////////////////////////////
   // Read channel

   assign rdAddr = rpAddr_e'(arAddr[4:2]);

   // Read word select, unmapped reads zero
   always_comb
   begin
      case (rdAddr)
         AddrCs1: rdWord = csWord;
         AddrDa:  rdWord = daWord;
         AddrMr:  rdWord = mrWord;
         AddrLa:  rdWord = laWord;
         AddrDs:  rdWord = dsWord;
         default: rdWord = '0;
      endcase
   end

   // Ready only with no read data pending
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         arReady <= 1'b0;
         rValid  <= 1'b0;
      end
      else if (arReady && arValid)
      begin
         arReady <= 1'b0;
         rValid  <= 1'b1;
      end
      else if (rValid && rReady)
      begin
         arReady <= 1'b1;
         rValid  <= 1'b0;
      end
      else if (!rValid)
         arReady <= 1'b1;
   end

   // Data captured at the address handshake
   always_ff @(posedge clk)
   begin
      if (arReady && arValid)
         rData <= {16'b0, rdWord};
   end

   assign rResp = RespOkay;

endmodule

//--- hdl/rpSectorGen.sv
////////////////////////////////////////////////////////////
// Free-running sector clock, starts counting at reset
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rpSectorGen #(
   parameter int SectorCycles    = 16,
   parameter int SectorsPerTrack = 22
) (
   input  logic clk,
   input  logic rst,
   output logic sectorTick,
   output logic indexTick
);

   localparam int CycleW  = (SectorCycles > 1) ? $clog2(SectorCycles) : 1;
   localparam int SectorW = (SectorsPerTrack > 1) ? $clog2(SectorsPerTrack) : 1;

   logic [CycleW-1:0]  cycleCnt;
   logic [SectorW-1:0] sectorCnt;
   logic               cycleEnd;

   // Last clock of a sector period
   assign cycleEnd = (cycleCnt == CycleW'(SectorCycles - 1));

   // Both pulses registered so they line up
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         cycleCnt   <= '0;
         sectorCnt  <= '0;
         sectorTick <= 1'b0;
         indexTick  <= 1'b0;
      end
      else
      begin
         sectorTick <= cycleEnd;
         // Index on the last sector of the track
         indexTick  <= cycleEnd && (sectorCnt == SectorW'(SectorsPerTrack - 1));
         if (cycleEnd)
         begin
            cycleCnt <= '0;
            if (sectorCnt == SectorW'(SectorsPerTrack - 1))
               sectorCnt <= '0;
            else
               sectorCnt <= sectorCnt + 1'b1;
         end
         else
            cycleCnt <= cycleCnt + 1'b1;
      end
   end

endmodule

//--- rpMaint/rpMaint.sv
////////////////////////////////////////////////////////////
// RPMR bits 4:1 hold only in diagnostic mode
// DMD itself loads only while the drive is idle
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rpMaint
   import rpPkg::*;
(
   input  logic        clk,
   input  logic        rst,
   input  logic        clr,
   rpRegBus.target     regBus,
   rpMaintIf.maint     maint,
   output logic [15:0] mrWord
);

   logic  mrWr;
   logic  dmd;
   logic  dclk;
   logic  dind;
   logic  dsck;
   logic  ddat;
   // Previous DSCK and DIND for edge detect
   logic  dsckQ;
   logic  dindQ;
   rpMr_s mr;

   assign mrWr = regBus.wrEn && (regBus.wrAddr == AddrMr);

   // Diagnostic mode bit
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         dmd <= 1'b0;
      else if (clr)
         dmd <= 1'b0;
      else if (mrWr && !maint.busy)
         dmd <= regBus.wrData.mr.dmd;
   end

   // Diagnostic bits, cleared whenever DMD is off
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         dclk <= 1'b0;
         dind <= 1'b0;
         dsck <= 1'b0;
         ddat <= 1'b0;
      end
      else if (!dmd)
      begin
         dclk <= 1'b0;
         dind <= 1'b0;
         dsck <= 1'b0;
         ddat <= 1'b0;
      end
      else if (mrWr)
      begin
         dclk <= regBus.wrData.mr.dclk;
         dind <= regBus.wrData.mr.dind;
         dsck <= regBus.wrData.mr.dsck;
         ddat <= regBus.wrData.mr.ddat;
      end
   end

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         dsckQ <= 1'b0;
         dindQ <= 1'b0;
      end
      else
      begin
         dsckQ <= dsck;
         dindQ <= dind;
      end
   end

   // One clock pulse on each software 0 to 1 toggle
   assign maint.sectorPulse = dsck && !dsckQ;
   assign maint.indexPulse  = dind && !dindQ;
   assign maint.dmd         = dmd;

   assign mr = '{rsvd: '0, ddat: ddat, dsck: dsck, dind: dind, dclk: dclk, dmd: dmd};
   assign mrWord = mr;

endmodule

//--- rpControl/rpControl.sv
////////////////////////////////////////////////////////////
// SEARCH waits forever if RPDA is past the last sector
// Commands issued while busy are ignored
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rpControl
   import rpPkg::*;
(
   input  logic        clk,
   input  logic        rst,
   rpRegBus.target     regBus,
   rpMaintIf.ctrl      maint,
   input  logic        sectorTick,
   input  logic        indexTick,
   output logic        clr,
   output logic [15:0] csWord,
   output logic [15:0] daWord,
   output logic [15:0] laWord,
   output logic [15:0] dsWord
);

   logic                  busy;
   logic                  attn;
   rpFunc_e               func;
   logic [SectorBits-1:0] da;
   logic [SectorBits-1:0] secCnt;
   logic [SectorBits-1:0] secNext;
   logic                  csWr;
   logic                  daWr;
   logic                  secSel;
   logic                  idxSel;
   logic                  done;
   rpCs1_s                cs;

   assign csWr = regBus.wrEn && (regBus.wrAddr == AddrCs1);
   assign daWr = regBus.wrEn && (regBus.wrAddr == AddrDa);

   ////////////////////////////////////////////////////////////
   // Sector counter

   // Pulse source follows diagnostic mode
   assign secSel = maint.dmd ? maint.sectorPulse : sectorTick;
   assign idxSel = maint.dmd ? maint.indexPulse : indexTick;

   // Index wins over sector advance
   always_comb
   begin
      if (idxSel)
         secNext = '0;
      else if (secSel)
         secNext = secCnt + 1'b1;
      else
         secNext = secCnt;
   end

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         secCnt <= '0;
         da     <= '0;
      end
      else
      begin
         secCnt <= secNext;
         if (daWr)
            da <= regBus.wrData.raw[SectorBits-1:0];
      end
   end

   ////////////////////////////////////////////////////////////
   // Function execution

   // Search ends on the sector pulse landing on RPDA, others at once
   assign done = busy && ((func != FuncSearch) || (secSel && (secNext == da)));

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         busy <= 1'b0;
         attn <= 1'b0;
         func <= FuncNop;
      end
      else
      begin
         if (csWr && !busy)
            func <= regBus.wrData.cs1.func;
         if (done)
         begin
            busy <= 1'b0;
            attn <= 1'b1;
         end
         else
         begin
            if (csWr && !busy && regBus.wrData.cs1.go)
               busy <= 1'b1;
            // Any RPCS1 write acknowledges attention
            if (csWr)
               attn <= 1'b0;
         end
      end
   end

   // Drive clear lasts for its single busy cycle
   assign clr        = busy && (func == FuncDrvClr);
   assign maint.busy = busy;

   ////////////////////////////////////////////////////////////
   // Read words

   // GO reads back as busy
   assign cs     = '{attn: attn, rsvd: '0, func: func, go: busy};
   assign csWord = cs;
   assign daWord = {{(16 - SectorBits){1'b0}}, da};
   assign laWord = {{(16 - SectorBits){1'b0}}, secCnt};

   always_comb
   begin
      dsWord        = '0;
      dsWord[DsDry] = !busy;
      dsWord[DsDmd] = maint.dmd;
   end

endmodule

//--- hdl/rpDrive.sv
////////////////////////////////////////////////////////////
// RP drive register model behind an AXI4-Lite port
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rpDrive #(
   parameter int SectorCycles    = 16,
   parameter int SectorsPerTrack = 22
) (
   input  logic        clk,
   input  logic        rst,
   input  logic [4:0]  awAddr,
   input  logic        awValid,
   output logic        awReady,
   input  logic [31:0] wData,
   input  logic        wValid,
   output logic        wReady,
   output logic        bValid,
   input  logic        bReady,
   output logic [1:0]  bResp,
   input  logic [4:0]  arAddr,
   input  logic        arValid,
   output logic        arReady,
   output logic [31:0] rData,
   output logic        rValid,
   input  logic        rReady,
   output logic [1:0]  rResp
);

   logic        sectorTick;
   logic        indexTick;
   logic        clr;
   logic [15:0] csWord;
   logic [15:0] daWord;
   logic [15:0] mrWord;
   logic [15:0] laWord;
   logic [15:0] dsWord;

   rpRegBus  regBus ();
   rpMaintIf maintIf ();

   // Bus front end
   rpAxiSlave i_rpAxiSlave (
      .clk, .rst,
      .awAddr, .awValid, .awReady, .wData, .wValid, .wReady,
      .bValid, .bReady, .bResp,
      .arAddr, .arValid, .arReady, .rData, .rValid, .rReady, .rResp,
      .regBus (regBus.master),
      .csWord, .daWord, .mrWord, .laWord, .dsWord
   );

   rpSectorGen #(
      .SectorCycles    (SectorCycles),
      .SectorsPerTrack (SectorsPerTrack)
   ) i_rpSectorGen (
      .clk, .rst, .sectorTick, .indexTick
   );

   // Maintenance register and control run side by side
   rpMaint i_rpMaint (
      .clk, .rst, .clr,
      .regBus (regBus.target),
      .maint  (maintIf.maint),
      .mrWord
   );

   rpControl i_rpControl (
      .clk, .rst,
      .regBus (regBus.target),
      .maint  (maintIf.ctrl),
      .sectorTick, .indexTick, .clr,
      .csWord, .daWord, .laWord, .dsWord
   );

endmodule

//--- sim/rpDrive_asserts.sv
////////////////////////////////////////////////////////////
// Bus protocol and RPMR read checks, bound into rpDrive
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rpDrive_asserts (
   input logic        clk,
   input logic        rst,
   input logic        awReady,
   input logic        wReady,
   input logic [4:0]  arAddr,
   input logic        arValid,
   input logic        arReady,
   input logic        bValid,
   input logic        bReady,
   input logic [1:0]  bResp,
   input logic        rValid,
   input logic        rReady,
   input logic [31:0] rData,
   input logic [1:0]  rResp
);

   // Failed assertions, read by the testbench
   int   errCount = 0;
   // Pending read targets RPMR
   logic rdIsMr;

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         rdIsMr <= 1'b0;
      else if (arValid && arReady)
         rdIsMr <= (arAddr[4:2] == 3'd2);
   end

   ////////////////////////////////////////////////////////////
   // Handshake rules

   // Write response held until taken
   bHold: assert property (@(posedge clk) disable iff (rst) bValid && !bReady |=> bValid)
      else
      begin
         errCount++;
         $error("write response dropped before bReady");
      end

   // Read data held and unchanged until taken
   rHold: assert property (@(posedge clk) disable iff (rst)
      rValid && !rReady |=> rValid && $stable(rData))
      else
      begin
         errCount++;
         $error("read data dropped or changed before rReady");
      end

   // Responses always OKAY
   respOkay: assert property (@(posedge clk) disable iff (rst)
      (bValid |-> bResp == 2'b00) and (rValid |-> rResp == 2'b00))
      else
      begin
         errCount++;
         $error("response code other than OKAY");
      end

   // Everything quiet while in reset
   resetQuiet: assert property (@(posedge clk)
      rst |-> !awReady && !wReady && !bValid && !arReady && !rValid)
      else
      begin
         errCount++;
         $error("handshake output high during reset");
      end

   ////////////////////////////////////////////////////////////
   // RPMR contents

   // Diagnostic bits never read back without DMD
   mrBits: assert property (@(posedge clk) disable iff (rst)
      rValid && rdIsMr && !rData[0] |-> rData[4:1] == 4'b0)
      else
      begin
         errCount++;
         $error("RPMR diagnostic bits read set with DMD clear");
      end

endmodule

bind rpDrive rpDrive_asserts i_rpDriveAsserts (
   .clk, .rst, .awReady, .wReady,
   .arAddr, .arValid, .arReady,
   .bValid, .bReady, .bResp,
   .rValid, .rReady, .rData, .rResp
);

//--- sim/rpDriveTb.sv
////////////////////////////////////////////////////////////
// Short sector period so a normal SEARCH ends quickly
// Response ready delays come from a fixed-seed LCG
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module rpDriveTb
   import rpPkg::*;
();

   // About four times the longest run
   localparam int CycleLimit = 20000;

   // RPMR bit images
   localparam logic [15:0] MrDmd  = 16'h0001;
   localparam logic [15:0] MrDind = 16'h0004;
   localparam logic [15:0] MrDsck = 16'h0008;

   logic        clk;
   logic        rst;
   logic [4:0]  awAddr;
   logic        awValid;
   logic        awReady;
   logic [31:0] wData;
   logic        wValid;
   logic        wReady;
   logic        bValid;
   logic        bReady;
   logic [1:0]  bResp;
   logic [4:0]  arAddr;
   logic        arValid;
   logic        arReady;
   logic [31:0] rData;
   logic        rValid;
   logic        rReady;
   logic [1:0]  rResp;

   logic [31:0] rngState = 32'hff9300ff;
   // Random ready delays on or off
   logic        pressureOn = 1'b1;
   int          valueErrors = 0;
   int          assertErrors;
   int          cycleCount = 0;

   rpDrive #(
      .SectorCycles    (8),
      .SectorsPerTrack (6)
   ) i_rpDrive (
      .clk, .rst,
      .awAddr, .awValid, .awReady, .wData, .wValid, .wReady,
      .bValid, .bReady, .bResp,
      .arAddr, .arValid, .arReady, .rData, .rValid, .rReady, .rResp
   );

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Run limit
   always @(posedge clk)
   begin
      cycleCount <= cycleCount + 1;
      if (cycleCount == CycleLimit)
      begin
         $display("Timeout: run still going after %0d clock cycles", CycleLimit);
         $display("sim failed");
         $finish;
      end
   end

   ////////////////////////////////////////////////////////////
   // Helpers

   function automatic logic [31:0] nextRandom();
      rngState = rngState * 32'd1664525 + 32'd1013904223;
      return rngState;
   endfunction

   // Ready level for bReady and rReady, high about 3 times in 4
   function automatic logic readyLevel();
      logic [31:0] rnd;
      if (!pressureOn)
         return 1'b1;
      rnd = nextRandom();
      return rnd[24] | rnd[25];
   endfunction

   // RPCS1 image, attn 15, func 5:1, go 0
   function automatic logic [15:0] csImage(input logic attn, input logic [4:0] func,
                                           input logic go);
      return {attn, 9'b0, func, go};
   endfunction

   // RPDS image, DRY at 7, DMD at 0
   function automatic logic [15:0] dsImage(input logic dry, input logic dmd);
      return {8'b0, dry, 6'b0, dmd};
   endfunction

   // One AXI write, returns on the edge that takes the response
   task automatic writeReg(input logic [2:0] idx, input logic [15:0] data);
      awAddr  <= {idx, 2'b00};
      wData   <= {16'h0, data};
      awValid <= 1'b1;
      wValid  <= 1'b1;
      do
         @(posedge clk);
      while (!(awReady && wReady));
      awValid <= 1'b0;
      wValid  <= 1'b0;
      bReady  <= readyLevel();
      forever
      begin
         @(posedge clk);
         if (bValid && bReady)
            break;
         bReady <= readyLevel();
      end
      bReady <= 1'b0;
   endtask

   // One AXI read, data sampled on the accepting edge
   task automatic readReg(input logic [2:0] idx, output logic [15:0] data);
      arAddr  <= {idx, 2'b00};
      arValid <= 1'b1;
      do
         @(posedge clk);
      while (!arReady);
      arValid <= 1'b0;
      rReady  <= readyLevel();
      forever
      begin
         @(posedge clk);
         if (rValid && rReady)
            break;
         rReady <= readyLevel();
      end
      data = rData[15:0];
      rReady <= 1'b0;
   endtask

   task automatic checkRead(input logic [2:0] idx, input logic [15:0] exp, input string what);
      logic [15:0] got;
      readReg(idx, got);
      assert (got === exp)
      else
      begin
         valueErrors++;
         $display("FAILED at %0t: %s read 0x%04h, expected 0x%04h", $time, what, got, exp);
      end
   endtask

   // Raise one diagnostic bit and drop it again, DMD kept on
   task automatic toggleMr(input logic [15:0] bits);
      writeReg(AddrMr, MrDmd | bits);
      writeReg(AddrMr, MrDmd);
   endtask

   ////////////////////////////////////////////////////////////
   // Stimulus

   initial
   begin
      logic [15:0] dsVal;
      logic [31:0] rnd;
      rst     = 1'b1;
      awAddr  = '0;
      awValid = 1'b0;
      wData   = '0;
      wValid  = 1'b0;
      bReady  = 1'b0;
      arAddr  = '0;
      arValid = 1'b0;
      rReady  = 1'b0;
      repeat (5) @(posedge clk);
      rst <= 1'b0;

      // Register access
      writeReg(AddrDa, 16'hffff);
      checkRead(AddrDa, 16'h003f, "RPDA masked");
      writeReg(AddrDa, 16'h0015);
      checkRead(AddrDa, 16'h0015, "RPDA");
      checkRead(3'd5, 16'h0000, "unmapped index 5");
      checkRead(3'd6, 16'h0000, "unmapped index 6");
      checkRead(3'd7, 16'h0000, "unmapped index 7");
      writeReg(AddrMr, 16'hfffe);
      checkRead(AddrMr, 16'h0000, "RPMR with DMD clear");

      // Diagnostic mode, all five bits stored
      writeReg(AddrMr, MrDmd);
      writeReg(AddrMr, 16'hffff);
      checkRead(AddrMr, 16'h001f, "RPMR in diagnostic mode");
      checkRead(AddrDs, dsImage(1'b1, 1'b1), "RPDS idle with DMD");
      writeReg(AddrMr, MrDmd);

      // Software sector pulses, index pulse resets the count
      toggleMr(MrDsck);
      checkRead(AddrLa, 16'd1, "RPLA after first DSCK");
      toggleMr(MrDsck);
      checkRead(AddrLa, 16'd2, "RPLA after second DSCK");
      toggleMr(MrDind);
      checkRead(AddrLa, 16'd0, "RPLA after DIND");

      // Diagnostic SEARCH for sector 3
      writeReg(AddrDa, 16'd3);
      writeReg(AddrCs1, csImage(1'b0, FuncSearch, 1'b1));
      checkRead(AddrCs1, csImage(1'b0, FuncSearch, 1'b1), "RPCS1 during SEARCH");
      checkRead(AddrDs, dsImage(1'b0, 1'b1), "RPDS busy");
      toggleMr(MrDsck);
      checkRead(AddrLa, 16'd1, "RPLA in SEARCH, edge 1");
      checkRead(AddrDs, dsImage(1'b0, 1'b1), "RPDS in SEARCH, edge 1");
      // DMD must survive a clearing write while busy
      writeReg(AddrMr, 16'h0000);
      checkRead(AddrMr, MrDmd, "RPMR after write during busy");
      toggleMr(MrDsck);
      checkRead(AddrLa, 16'd2, "RPLA in SEARCH, edge 2");
      checkRead(AddrDs, dsImage(1'b0, 1'b1), "RPDS in SEARCH, edge 2");
      toggleMr(MrDsck);
      checkRead(AddrLa, 16'd3, "RPLA at end of SEARCH");
      checkRead(AddrDs, dsImage(1'b1, 1'b1), "RPDS at end of SEARCH");
      checkRead(AddrCs1, csImage(1'b1, FuncSearch, 1'b0), "RPCS1 attn after SEARCH");

      // Normal SEARCH on the free-running generator
      writeReg(AddrMr, 16'h0000);
      writeReg(AddrDa, 16'd4);
      // Tight polling so the counter cannot move before RPLA is read
      pressureOn = 1'b0;
      writeReg(AddrCs1, csImage(1'b0, FuncSearch, 1'b1));
      dsVal = '0;
      while (!dsVal[7])
         readReg(AddrDs, dsVal);
      checkRead(AddrLa, 16'd4, "RPLA after normal SEARCH");
      pressureOn = 1'b1;
      checkRead(AddrDs, dsImage(1'b1, 1'b0), "RPDS after normal SEARCH");

      // DRIVE CLEAR drops diagnostic mode
      writeReg(AddrMr, MrDmd);
      writeReg(AddrMr, 16'h001f);
      writeReg(AddrCs1, csImage(1'b0, FuncDrvClr, 1'b1));
      checkRead(AddrDs, dsImage(1'b1, 1'b0), "RPDS after DRIVE CLEAR");
      checkRead(AddrMr, 16'h0000, "RPMR after DRIVE CLEAR");
      checkRead(AddrCs1, csImage(1'b1, FuncDrvClr, 1'b0), "RPCS1 attn after DRIVE CLEAR");
      writeReg(AddrCs1, csImage(1'b0, FuncNop, 1'b0));
      checkRead(AddrCs1, 16'h0000, "RPCS1 after attn clear");

      // Random data under random ready delays
      for (int i = 0; i < 16; i++)
      begin
         rnd = nextRandom();
         writeReg(AddrDa, rnd[15:0]);
         checkRead(AddrDa, {10'b0, rnd[5:0]}, "RPDA under back-pressure");
      end

      @(posedge clk);
      assertErrors = i_rpDrive.i_rpDriveAsserts.errCount;
      $display("Value errors: %0d, assertion errors: %0d", valueErrors, assertErrors);
      if (valueErrors == 0 && assertErrors == 0)
         $display("sim passed");
      else
         $display("sim failed");
      $finish;
   end

endmodule

//--- rpDrive.f
common/rpPkg.sv
common/rpBusIfs.sv
hdl/rpAxiSlave.sv
hdl/rpSectorGen.sv
rpMaint/rpMaint.sv
rpControl/rpControl.sv
hdl/rpDrive.sv
sim/rpDrive_asserts.sv
sim/rpDriveTb.sv
